// ==== project.f ====
rtl/stackPkg.sv
rtl/stackIfs.sv
rtl/cmdIntake.sv
rtl/stackSequencer.sv
rtl/stackDatapath.sv
rtl/stackRam.sv
rtl/stackTop.sv
test/stack_properties.sv
test/stackTb.sv

// ==== rtl/cmdIntake.sv ====
`timescale 1ns/1ps

module cmdIntake (
    input logic clk,
    input logic arstN,
    input logic req,
    input stackPkg::stackOp_t op,
    input logic [stackPkg::dataW-1:0] value,
    output logic ack,
    cmdIf.intake cmd
);

    typedef enum logic [1:0] {hsIdle, hsBusy, hsAcked} hsState_t;

    hsState_t hsState;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hsState <= hsIdle;
            cmd.start <= 1'b0;
            ack <= 1'b0;
        end else begin
            cmd.start <= 1'b0;
            case (hsState)
                hsIdle: begin
                    if (req) begin
                        cmd.start <= 1'b1;
                        hsState <= hsBusy;
                    end
                end
                hsBusy: begin
                    if (cmd.done) begin
                        ack <= 1'b1;
                        hsState <= hsAcked;
                    end
                end
                hsAcked: begin
                    // hold ack until the outside lets go of req
                    if (!req) begin
                        ack <= 1'b0;
                        hsState <= hsIdle;
                    end
                end
                default: hsState <= hsIdle;
            endcase
        end
    end

    // command captured at start, held for the sequencer
    always_ff @(posedge clk) begin
        if (hsState == hsIdle && req) begin
            cmd.op <= op;
            cmd.value <= value;
        end
    end

endmodule

// ==== rtl/stackDatapath.sv ====
`timescale 1ns/1ps

module stackDatapath (
    input logic clk,
    input logic arstN,
    input stackPkg::ctrlWord_t ctrl,
    cmdIf.dp cmd,
    memIf.dp mem,
    output logic [stackPkg::dataW-1:0] topValue,
    output logic stackEmpty
);

    logic [stackPkg::addrW-1:0] spr;
    logic [stackPkg::addrW-1:0] dar;
    logic [stackPkg::dataW-1:0] dvr;
    logic [stackPkg::dataW-1:0] opA;
    logic [stackPkg::dataW-1:0] opB;
    logic [stackPkg::addrW-1:0] sprNext;
    logic [stackPkg::addrW-1:0] darNext;
    logic [stackPkg::dataW-1:0] dvrNext;
    logic [stackPkg::dataW-1:0] aluOut;

    always_comb begin
        case (ctrl.sprSel)
            stackPkg::sprDec: sprNext = spr - 1'b1;
            stackPkg::sprInc: sprNext = spr + 1'b1;
            default: sprNext = stackPkg::stackBase;
        endcase
    end

    // top entry sits one above the pointer
    assign darNext = (ctrl.darSel == stackPkg::darSprPlusOne) ? spr + 1'b1 : '0;

    always_comb begin
        case (ctrl.dvrSel)
            stackPkg::dvrMem: dvrNext = mem.rdData;
            stackPkg::dvrAlu: dvrNext = aluOut;
            default: dvrNext = stackPkg::dvrInit;
        endcase
    end

    // wraps modulo 256
    assign aluOut = (ctrl.aluOp == stackPkg::aluSub) ? opA - opB : opA + opB;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            spr <= stackPkg::stackBase;
            dar <= '0;
            dvr <= stackPkg::dvrInit;
        end else begin
            if (ctrl.ldSpr) spr <= sprNext;
            if (ctrl.ldDar) dar <= darNext;
            if (ctrl.ldDvr) dvr <= dvrNext;
        end
    end

    // operands come straight from the read port
    always_ff @(posedge clk) begin
        if (ctrl.ldOpA) opA <= mem.rdData;
        if (ctrl.ldOpB) opB <= mem.rdData;
    end

    assign mem.addr = (ctrl.addrSel == stackPkg::addrDar) ? dar : spr;
    assign mem.wrData = ctrl.wrAlu ? aluOut : cmd.value;

    assign topValue = dvr;
    assign stackEmpty = (spr == stackPkg::stackBase);

endmodule

// ==== rtl/stackIfs.sv ====
`timescale 1ns/1ps

interface cmdIf;
    logic start;
    stackPkg::stackOp_t op;
    logic [stackPkg::dataW-1:0] value;
    logic done;

    modport intake (output start, output op, output value, input done);
    modport seq (input start, input op, output done);
    modport dp (input value);
endinterface

interface memIf;
    logic cs;
    logic we;
    logic [stackPkg::addrW-1:0] addr;
    logic [stackPkg::dataW-1:0] wrData;
    logic [stackPkg::dataW-1:0] rdData;

    modport seq (output cs, output we);
    modport dp (output addr, output wrData, input rdData);
    modport ram (input cs, input we, input addr, input wrData, output rdData);
endinterface

// ==== rtl/stackPkg.sv ====
package stackPkg;

    localparam int dataW = 8;
    localparam int addrW = 7;

    // empty stack pointer and display value after reset or clear
    localparam logic [addrW-1:0] stackBase = '1;
    localparam logic [dataW-1:0] dvrInit = '1;

    typedef enum logic [2:0] {
        opClear,
        opPush,
        opPop,
        opAdd,
        opSub
    } stackOp_t;

    typedef enum logic [4:0] {
        stIdle,
        stClear,
        stPush,
        stSprDec,
        stDarSet,
        stRequest,
        stLoad,
        stPop,
        stAddIncB,
        stAddReqB,
        stAddLoadB,
        stAddIncA,
        stAddReqA,
        stAddLoadA,
        stAddStore,
        stSubIncB,
        stSubReqB,
        stSubLoadB,
        stSubIncA,
        stSubReqA,
        stSubLoadA,
        stSubStore
    } uState_t;

    typedef enum logic [1:0] {sprInit, sprDec, sprInc} sprSel_t;
    typedef enum logic {darInit, darSprPlusOne} darSel_t;
    // dvrSelInit picks the dvrInit constant
    typedef enum logic [1:0] {dvrSelInit, dvrMem, dvrAlu} dvrSel_t;
    typedef enum logic {aluAdd, aluSub} aluOp_t;
    typedef enum logic {addrSpr, addrDar} addrSel_t;

    // all-zero word is a no-op
    typedef struct packed {
        sprSel_t sprSel;
        logic ldSpr;
        darSel_t darSel;
        logic ldDar;
        dvrSel_t dvrSel;
        logic ldDvr;
        addrSel_t addrSel;
        logic ldOpA;
        logic ldOpB;
        aluOp_t aluOp;
        logic wrAlu;
        logic cs;
        logic we;
    } ctrlWord_t;

endpackage

// ==== rtl/stackRam.sv ====
`timescale 1ns/1ps

module stackRam (
    input logic clk,
    memIf.ram mem
);

    logic [stackPkg::dataW-1:0] store [0:(1 << stackPkg::addrW)-1];

    // read word is registered, valid the cycle after the request
    always_ff @(posedge clk) begin
        if (mem.cs) begin
            if (mem.we) begin
                store[mem.addr] <= mem.wrData;
            end else begin
                mem.rdData <= store[mem.addr];
            end
        end
    end

endmodule

// ==== rtl/stackSequencer.sv ====
`timescale 1ns/1ps

module stackSequencer (
    input logic clk,
    input logic arstN,
    cmdIf.seq cmd,
    memIf.seq mem,
    output stackPkg::ctrlWord_t ctrl
);

    stackPkg::uState_t state;
    stackPkg::uState_t uNext;
    stackPkg::uState_t nextState;
    stackPkg::ctrlWord_t uCtrl;

    // microcode table
    always_comb begin
        uCtrl = '0;
        uNext = stackPkg::stIdle;
        case (state)
            stackPkg::stIdle: uNext = stackPkg::stIdle;
            stackPkg::stClear: begin
                uCtrl.ldSpr = 1'b1;
                uCtrl.ldDar = 1'b1;
                uCtrl.ldDvr = 1'b1;
            end
            stackPkg::stPush: begin
                uCtrl.cs = 1'b1;
                uCtrl.we = 1'b1;
                uNext = stackPkg::stSprDec;
            end
            stackPkg::stSprDec: begin
                uCtrl.sprSel = stackPkg::sprDec;
                uCtrl.ldSpr = 1'b1;
                uNext = stackPkg::stDarSet;
            end
            // shared read-back tail of push and pop
            stackPkg::stDarSet: begin
                uCtrl.darSel = stackPkg::darSprPlusOne;
                uCtrl.ldDar = 1'b1;
                uNext = stackPkg::stRequest;
            end
            stackPkg::stRequest: begin
                uCtrl.addrSel = stackPkg::addrDar;
                uCtrl.cs = 1'b1;
                uNext = stackPkg::stLoad;
            end
            stackPkg::stLoad: begin
                uCtrl.dvrSel = stackPkg::dvrMem;
                uCtrl.ldDvr = 1'b1;
            end
            stackPkg::stPop: begin
                uCtrl.sprSel = stackPkg::sprInc;
                uCtrl.ldSpr = 1'b1;
                uNext = stackPkg::stDarSet;
            end
            stackPkg::stAddIncB, stackPkg::stSubIncB,
            stackPkg::stAddIncA, stackPkg::stSubIncA: begin
                uCtrl.sprSel = stackPkg::sprInc;
                uCtrl.ldSpr = 1'b1;
                uNext = stackPkg::uState_t'(state + 5'd1);
            end
            stackPkg::stAddReqB, stackPkg::stSubReqB,
            stackPkg::stAddReqA, stackPkg::stSubReqA: begin
                uCtrl.cs = 1'b1;
                uNext = stackPkg::uState_t'(state + 5'd1);
            end
            stackPkg::stAddLoadB, stackPkg::stSubLoadB: begin
                uCtrl.ldOpB = 1'b1;
                uNext = stackPkg::uState_t'(state + 5'd1);
            end
            stackPkg::stAddLoadA, stackPkg::stSubLoadA: begin
                uCtrl.ldOpA = 1'b1;
                uNext = stackPkg::uState_t'(state + 5'd1);
            end
            // result goes to the deeper slot, which then becomes the top
            stackPkg::stAddStore, stackPkg::stSubStore: begin
                uCtrl.aluOp = (state == stackPkg::stSubStore) ?
                              stackPkg::aluSub : stackPkg::aluAdd;
                uCtrl.wrAlu = 1'b1;
                uCtrl.cs = 1'b1;
                uCtrl.we = 1'b1;
                uCtrl.sprSel = stackPkg::sprDec;
                uCtrl.ldSpr = 1'b1;
                uCtrl.dvrSel = stackPkg::dvrAlu;
                uCtrl.ldDvr = 1'b1;
            end
            default: uNext = stackPkg::stIdle;
        endcase
    end

    // idle dispatches on the opcode, everything else follows the table
    always_comb begin
        nextState = uNext;
        if (state == stackPkg::stIdle && cmd.start) begin
            case (cmd.op)
                stackPkg::opClear: nextState = stackPkg::stClear;
                stackPkg::opPush: nextState = stackPkg::stPush;
                stackPkg::opPop: nextState = stackPkg::stPop;
                stackPkg::opAdd: nextState = stackPkg::stAddIncB;
                stackPkg::opSub: nextState = stackPkg::stSubIncB;
                default: nextState = stackPkg::stIdle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stackPkg::stIdle;
        end else begin
            state <= nextState;
        end
    end

    assign ctrl = uCtrl;
    assign mem.cs = uCtrl.cs;
    assign mem.we = uCtrl.we;
    assign cmd.done = (state != stackPkg::stIdle) && (uNext == stackPkg::stIdle);

endmodule

// ==== rtl/stackTop.sv ====
`timescale 1ns/1ps

module stackTop (
    input logic clk,
    input logic arstN,
    input logic req,
    input stackPkg::stackOp_t op,
    input logic [stackPkg::dataW-1:0] value,
    output logic ack,
    output logic [stackPkg::dataW-1:0] topValue,
    output logic stackEmpty
);

    stackPkg::ctrlWord_t ctrl;

    cmdIf cmdBus ();
    memIf memBus ();

    cmdIntake intake0 (
        .clk(clk),
        .arstN(arstN),
        .req(req),
        .op(op),
        .value(value),
        .ack(ack),
        .cmd(cmdBus.intake)
    );

    stackSequencer seq0 (
        .clk(clk),
        .arstN(arstN),
        .cmd(cmdBus.seq),
        .mem(memBus.seq),
        .ctrl(ctrl)
    );

    stackDatapath dp0 (
        .clk(clk),
        .arstN(arstN),
        .ctrl(ctrl),
        .cmd(cmdBus.dp),
        .mem(memBus.dp),
        .topValue(topValue),
        .stackEmpty(stackEmpty)
    );

    stackRam ram0 (
        .clk(clk),
        .mem(memBus.ram)
    );

endmodule

// ==== test/stackTb.sv ====
`timescale 1ns/1ps

module stackTb;

    localparam int timeoutCycles = 200;
    localparam int randomCmds = 80;
    localparam int maxDepth = 20;

    logic clk;
    logic arstN;
    logic req;
    stackPkg::stackOp_t op;
    logic [stackPkg::dataW-1:0] value;
    logic ack;
    logic [stackPkg::dataW-1:0] topValue;
    logic stackEmpty;

    logic [31:0] lcgState;
    logic [stackPkg::dataW-1:0] model [$];
    logic [stackPkg::dataW-1:0] seenTop;
    logic seenEmpty;
    int passCount;
    int failCount;
    bit aborted;

    stackTop dut0 (
        .clk(clk),
        .arstN(arstN),
        .req(req),
        .op(op),
        .value(value),
        .ack(ack),
        .topValue(topValue),
        .stackEmpty(stackEmpty)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic reportFail(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
        failCount++;
    endtask

    task automatic reportPass(input string name);
        $display("[PASS] %s", name);
        passCount++;
    endtask

    task automatic reportError(input string what);
        $display("[ERROR] %s", what);
        failCount++;
    endtask

    // one full four-phase handshake with outputs captured when ack rises
    task automatic runCommand(input string name, input stackPkg::stackOp_t cmdOp,
                              input logic [stackPkg::dataW-1:0] cmdValue);
        int waitCount;
        int holdCycles;
        logic [31:0] r;
        if (aborted) return;
        r = nextRand();
        holdCycles = r[17:16];
        @(posedge clk);
        req <= 1'b1;
        op <= cmdOp;
        value <= cmdValue;
        waitCount = 0;
        @(negedge clk);
        while (!ack && waitCount < timeoutCycles) begin
            @(negedge clk);
            waitCount++;
        end
        if (!ack) begin
            reportError($sformatf("ack did not rise within %0d cycles for %s",
                                  timeoutCycles, name));
            aborted = 1'b1;
            return;
        end
        seenTop = topValue;
        seenEmpty = stackEmpty;
        // outside holds req so ack has to stay up
        repeat (holdCycles) begin
            @(negedge clk);
            if (!ack) begin
                reportError($sformatf("ack dropped while req was still high for %s", name));
            end
        end
        @(posedge clk);
        req <= 1'b0;
        waitCount = 0;
        @(negedge clk);
        while (ack && waitCount < timeoutCycles) begin
            @(negedge clk);
            waitCount++;
        end
        if (ack) begin
            reportError($sformatf("ack did not fall within %0d cycles after req dropped for %s",
                                  timeoutCycles, name));
            aborted = 1'b1;
        end
    endtask

    task automatic pushAndCheck(input string name, input logic [stackPkg::dataW-1:0] v);
        runCommand(name, stackPkg::opPush, v);
        if (aborted) return;
        model.push_back(v);
        if (seenTop !== v) reportFail(name, v, seenTop);
        else reportPass(name);
        if (seenEmpty !== 1'b0) reportFail({name, " empty"}, 0, seenEmpty);
        else reportPass({name, " empty"});
    endtask

    task automatic popAndCheck(input string name);
        runCommand(name, stackPkg::opPop, 8'h00);
        if (aborted) return;
        void'(model.pop_back());
        if (model.size() == 0) begin
            if (seenEmpty !== 1'b1) reportFail({name, " empty"}, 1, seenEmpty);
            else reportPass({name, " empty"});
        end else begin
            if (seenEmpty !== 1'b0) reportFail({name, " empty"}, 0, seenEmpty);
            else reportPass({name, " empty"});
            if (seenTop !== model[$]) reportFail(name, model[$], seenTop);
            else reportPass(name);
        end
    endtask

    task automatic arithAndCheck(input string name, input bit isSub);
        logic [stackPkg::dataW-1:0] topEntry;
        logic [stackPkg::dataW-1:0] deeper;
        logic [stackPkg::dataW-1:0] expected;
        if (aborted) return;
        topEntry = model[$];
        deeper = model[$-1];
        // results wrap in 8 bits
        expected = isSub ? deeper - topEntry : deeper + topEntry;
        runCommand(name, isSub ? stackPkg::opSub : stackPkg::opAdd, 8'h00);
        if (aborted) return;
        void'(model.pop_back());
        void'(model.pop_back());
        model.push_back(expected);
        if (seenTop !== expected) reportFail(name, expected, seenTop);
        else reportPass(name);
        if (seenEmpty !== 1'b0) reportFail({name, " empty"}, 0, seenEmpty);
        else reportPass({name, " empty"});
    endtask

    task automatic clearAndCheck(input string name);
        runCommand(name, stackPkg::opClear, 8'h00);
        if (aborted) return;
        model.delete();
        if (seenTop !== 8'hff) reportFail(name, 8'hff, seenTop);
        else reportPass(name);
        if (seenEmpty !== 1'b1) reportFail({name, " empty"}, 1, seenEmpty);
        else reportPass({name, " empty"});
    endtask

    initial begin
        logic [31:0] r;
        int sel;
        int kind;
        int depth;
        clk = 1'b0;
        arstN = 1'b0;
        req = 1'b0;
        op = stackPkg::opClear;
        value = '0;
        lcgState = 32'd36447;
        passCount = 0;
        failCount = 0;
        aborted = 1'b0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);

        if (topValue !== 8'hff) reportFail("reset top", 8'hff, topValue);
        else reportPass("reset top");
        if (stackEmpty !== 1'b1) reportFail("reset empty", 1, stackEmpty);
        else reportPass("reset empty");

        // arithmetic, then pops to show the deeper entries survived
        for (int i = 0; i < 3; i++) begin
            r = nextRand();
            pushAndCheck($sformatf("arith push %0d", i), r[23:16]);
        end
        arithAndCheck("arith add", 1'b0);
        popAndCheck("arith pop after add");
        for (int i = 0; i < 2; i++) begin
            r = nextRand();
            pushAndCheck($sformatf("arith push %0d", i + 3), r[23:16]);
        end
        arithAndCheck("arith sub", 1'b1);
        popAndCheck("arith pop after sub");
        popAndCheck("arith pop to empty");

        for (int i = 0; i < 4; i++) begin
            r = nextRand();
            pushAndCheck($sformatf("clear push %0d", i), r[23:16]);
        end
        clearAndCheck("clear");
        r = nextRand();
        pushAndCheck("push after clear", r[23:16]);

        for (int i = 0; i < randomCmds && !aborted; i++) begin
            r = nextRand();
            sel = r[19:16];
            depth = model.size();
            if (sel == 0) kind = 0;
            else if (sel <= 6) kind = 1;
            else if (sel <= 9) kind = 2;
            else if (sel <= 12) kind = 3;
            else kind = 4;
            // only legal commands
            if ((kind == 3 || kind == 4) && depth < 2) kind = 1;
            if (kind == 2 && depth < 1) kind = 1;
            if (kind == 1 && depth >= maxDepth) kind = 2;
            r = nextRand();
            case (kind)
                0: clearAndCheck($sformatf("random %0d clear", i));
                1: pushAndCheck($sformatf("random %0d push", i), r[23:16]);
                2: popAndCheck($sformatf("random %0d pop", i));
                3: arithAndCheck($sformatf("random %0d add", i), 1'b0);
                default: arithAndCheck($sformatf("random %0d sub", i), 1'b1);
            endcase
        end

        while (model.size() > 0 && !aborted) begin
            popAndCheck($sformatf("drain pop depth %0d", model.size()));
        end

        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== test/stack_properties.sv ====
`timescale 1ns/1ps

module stackProperties (
    input logic clk,
    input logic arstN,
    input logic req,
    input logic ack,
    input logic start,
    input logic cs,
    input logic we
);

    // ack only answers a pending request
    ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    weNeedsCs: assert property (@(posedge clk) disable iff (!arstN)
        we |-> cs)
        else $error("memory write strobe without chip select");

    startIsPulse: assert property (@(posedge clk) disable iff (!arstN)
        start |=> !start)
        else $error("start high for two cycles in a row");

    // release takes one edge to see req low, one more to drop ack
    ackReleases: assert property (@(posedge clk) disable iff (!arstN)
        $fell(req) |-> ##[0:2] !ack)
        else $error("ack still high two cycles after req fell");

endmodule

bind stackTop stackProperties props0 (
    .clk(clk),
    .arstN(arstN),
    .req(req),
    .ack(ack),
    .start(cmdBus.start),
    .cs(memBus.cs),
    .we(memBus.we)
);
